//--- sim.f
source/rv_isa_pkg.sv
source/bpred_pkg.sv
source/branch_decode.sv
source/branch_execute.sv
source/tournament_predictor.sv
source/branch_result.sv
source/branch_unit_top.sv
verif/branch_unit_tb.sv

//--- source/bpred_pkg.sv
package bpred_pkg;

    // local and meta tables index with pc[7:2]
    localparam int LOCAL_INDEX_BITS = 6;

    // global table index is pc[7:2] xor history
    localparam int GLOBAL_HISTORY_BITS = 6;

    // entries per counter table
    localparam int TABLE_ENTRIES = 1 << LOCAL_INDEX_BITS;

    // 2-bit saturating counter
    // msb is the taken / choose-global decision
    typedef logic [1:0] counter_t;

    // weak not-taken
    // for meta this is weakly choose local
    localparam counter_t COUNTER_RESET = 2'b01;

endpackage

//--- source/branch_decode.sv
module branch_decode (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         instr_valid,
    input  logic [31:0]                  instr_pc,
    input  logic [31:0]                  instr_word,
    input  logic [31:0]                  rs1_data,
    input  logic [31:0]                  rs2_data,
    output logic [31:0]                  lookup_pc,
    input  logic                         pred_taken,
    output logic                         dec_valid,
    output rv_isa_pkg::branch_kind_e     dec_kind,
    output rv_isa_pkg::branch_funct3_e   dec_funct3,
    output logic [31:0]                  dec_pc,
    output logic [31:0]                  dec_imm,
    output logic [31:0]                  dec_rs1_data,
    output logic [31:0]                  dec_rs2_data,
    output logic                         dec_pred_taken
);
    import rv_isa_pkg::*;

    opcode_e      opcode;
    logic [2:0]   funct3_raw;
    logic [31:0]  imm_b;
    logic [31:0]  imm_j;
    logic [31:0]  imm_i;
    branch_kind_e kind;
    logic [31:0]  imm;

    // predictor looks up the raw pc, answer comes back this cycle
    assign lookup_pc = instr_pc;

    assign opcode     = opcode_e'(instr_word[6:0]);
    assign funct3_raw = instr_word[14:12];

    // sign-extended immediates, bit 0 implied zero for B and J
    assign imm_b = {{20{instr_word[31]}}, instr_word[7], instr_word[30:25],
                    instr_word[11:8], 1'b0};
    assign imm_j = {{12{instr_word[31]}}, instr_word[19:12], instr_word[20],
                    instr_word[30:21], 1'b0};
    assign imm_i = {{21{instr_word[31]}}, instr_word[30:20]};

    always_comb begin
        kind = KIND_NONE;
        imm  = imm_i;
        case (opcode)
            OPC_BRANCH: begin
                // unused funct3 010/011 falls out as other
                if (funct3_raw[2:1] != 2'b01) begin
                    kind = KIND_COND;
                end
                imm = imm_b;
            end
            OPC_JAL: begin
                kind = KIND_JAL;
                imm  = imm_j;
            end
            OPC_JALR: begin
                kind = KIND_JALR;
            end
            default: begin
                kind = KIND_NONE;
            end
        endcase
    end

    // non-branches drop out here
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid && (kind != KIND_NONE);
        end
    end

    always_ff @(posedge clk) begin
        dec_kind       <= kind;
        dec_funct3     <= branch_funct3_e'(funct3_raw);
        dec_pc         <= instr_pc;
        dec_imm        <= imm;
        dec_rs1_data   <= rs1_data;
        dec_rs2_data   <= rs2_data;
        dec_pred_taken <= pred_taken;
    end

    // every live stage-2 entry is a real branch or jump
    a_dec_kind_live: assert property (@(posedge clk) disable iff (reset)
        dec_valid |-> (dec_kind != KIND_NONE));

endmodule

//--- source/branch_execute.sv
module branch_execute (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         dec_valid,
    input  rv_isa_pkg::branch_kind_e     dec_kind,
    input  rv_isa_pkg::branch_funct3_e   dec_funct3,
    input  logic [31:0]                  dec_pc,
    input  logic [31:0]                  dec_imm,
    input  logic [31:0]                  dec_rs1_data,
    input  logic [31:0]                  dec_rs2_data,
    input  logic                         dec_pred_taken,
    output logic                         ex_valid,
    output rv_isa_pkg::branch_kind_e     ex_kind,
    output logic [31:0]                  ex_pc,
    output logic                         ex_taken,
    output logic [31:0]                  ex_target,
    output logic                         ex_pred_taken
);
    import rv_isa_pkg::*;

    logic        cond_true;
    logic        taken;
    logic [31:0] target_base;
    logic [31:0] target_sum;
    logic [31:0] target;

    // funct3 selects the compare
    always_comb begin
        case (dec_funct3)
            BEQ:     cond_true = (dec_rs1_data == dec_rs2_data);
            BNE:     cond_true = (dec_rs1_data != dec_rs2_data);
            BLT:     cond_true = ($signed(dec_rs1_data) < $signed(dec_rs2_data));
            BGE:     cond_true = ($signed(dec_rs1_data) >= $signed(dec_rs2_data));
            BLTU:    cond_true = (dec_rs1_data < dec_rs2_data);
            BGEU:    cond_true = (dec_rs1_data >= dec_rs2_data);
            default: cond_true = 1'b0;
        endcase
    end

    // jumps always go
    assign taken = (dec_kind == KIND_COND) ? cond_true : 1'b1;

    // jalr is register relative, the rest pc relative
    assign target_base = (dec_kind == KIND_JALR) ? dec_rs1_data : dec_pc;
    assign target_sum  = target_base + dec_imm;
    assign target      = (dec_kind == KIND_JALR) ? {target_sum[31:1], 1'b0} : target_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_kind       <= dec_kind;
        ex_pc         <= dec_pc;
        ex_taken      <= taken;
        ex_target     <= target;
        ex_pred_taken <= dec_pred_taken;
    end

    // jalr target reaches result already halfword-cleared
    a_jalr_bit0: assert property (@(posedge clk) disable iff (reset)
        (ex_valid && ex_kind == KIND_JALR) |-> (ex_target[0] == 1'b0));

endmodule

//--- source/branch_result.sv
module branch_result (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ex_valid,
    input  rv_isa_pkg::branch_kind_e   ex_kind,
    input  logic [31:0]                ex_pc,
    input  logic                       ex_taken,
    input  logic [31:0]                ex_target,
    input  logic                       ex_pred_taken,
    output logic                       train_valid,
    output logic [31:0]                train_pc,
    output logic                       train_taken,
    output logic                       result_valid,
    output rv_isa_pkg::branch_kind_e   result_kind,
    output logic                       result_taken,
    output logic [31:0]                result_pc_next,
    output logic [31:0]                link_data,
    output logic                       mispredict
);
    import rv_isa_pkg::*;

    logic [31:0] pc_plus4;
    logic [31:0] pc_next;
    logic        mispredict_raw;

    assign pc_plus4 = ex_pc + 32'd4;
    assign pc_next  = ex_taken ? ex_target : pc_plus4;

    // jal target is exact, jalr never predicted
    always_comb begin
        case (ex_kind)
            KIND_COND: mispredict_raw = (ex_pred_taken != ex_taken);
            KIND_JALR: mispredict_raw = 1'b1;
            default:   mispredict_raw = 1'b0;
        endcase
    end

    // train conditionals only, same edge as the result register
    assign train_valid = ex_valid && (ex_kind == KIND_COND);
    assign train_pc    = ex_pc;
    assign train_taken = ex_taken;

    // result_valid and mispredict are strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            mispredict   <= 1'b0;
        end else begin
            result_valid <= ex_valid;
            mispredict   <= ex_valid && mispredict_raw;
        end
    end

    always_ff @(posedge clk) begin
        result_kind    <= ex_kind;
        result_taken   <= ex_taken;
        result_pc_next <= pc_next;
        link_data      <= pc_plus4;
    end

endmodule

//--- source/branch_unit_top.sv
module branch_unit_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    input  logic [31:0]                instr_pc,
    input  logic [31:0]                instr_word,
    input  logic [31:0]                rs1_data,
    input  logic [31:0]                rs2_data,
    output logic                       result_valid,
    output rv_isa_pkg::branch_kind_e   result_kind,
    output logic                       result_taken,
    output logic [31:0]                result_pc_next,
    output logic [31:0]                link_data,
    output logic                       mispredict
);
    import rv_isa_pkg::*;

    // decode to predictor, same cycle
    logic [31:0]    lookup_pc;
    logic           pred_taken;

    // decode to execute
    logic           dec_valid;
    branch_kind_e   dec_kind;
    branch_funct3_e dec_funct3;
    logic [31:0]    dec_pc;
    logic [31:0]    dec_imm;
    logic [31:0]    dec_rs1_data;
    logic [31:0]    dec_rs2_data;
    logic           dec_pred_taken;

    // execute to result
    logic           ex_valid;
    branch_kind_e   ex_kind;
    logic [31:0]    ex_pc;
    logic           ex_taken;
    logic [31:0]    ex_target;
    logic           ex_pred_taken;

    // result back to predictor
    logic           train_valid;
    logic [31:0]    train_pc;
    logic           train_taken;

    // port names line up stage to stage
    branch_decode        u_decode    (.*);
    tournament_predictor u_predictor (.*);
    branch_execute       u_execute   (.*);
    branch_result        u_result    (.*);

endmodule

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes that matter to branch resolution
    // anything else decodes as "other"
    typedef enum logic [6:0] {
        // conditional branches, B-type immediate
        OPC_BRANCH = 7'b1100011,
        // jump and link, J-type immediate
        OPC_JAL    = 7'b1101111,
        // jump and link register, I-type immediate
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // funct3 of the BRANCH opcode
    // 010 and 011 are unused encodings
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        // signed compares
        BLT  = 3'b100,
        BGE  = 3'b101,
        // unsigned compares
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_funct3_e;

    // control transfer class, carried down every stage
    typedef enum logic [1:0] {
        // not a branch, dropped at decode
        KIND_NONE = 2'b00,
        // conditional, predicted by the tournament tables
        KIND_COND = 2'b01,
        // always taken, target known at decode
        KIND_JAL  = 2'b10,
        // always taken, target never predicted
        KIND_JALR = 2'b11
    } branch_kind_e;

endpackage

//--- source/tournament_predictor.sv
module tournament_predictor (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] lookup_pc,
    output logic        pred_taken,
    input  logic        train_valid,
    input  logic [31:0] train_pc,
    input  logic        train_taken
);
    import bpred_pkg::*;

    counter_t local_table  [TABLE_ENTRIES];
    counter_t global_table [TABLE_ENTRIES];
    counter_t meta_table   [TABLE_ENTRIES];

    // resolved outcomes only, newest in bit 0
    logic [GLOBAL_HISTORY_BITS-1:0] history;

    logic [LOCAL_INDEX_BITS-1:0]    lk_local_idx;
    logic [GLOBAL_HISTORY_BITS-1:0] lk_global_idx;
    logic                           lk_local_taken;
    logic                           lk_global_taken;
    logic                           lk_use_global;

    logic [LOCAL_INDEX_BITS-1:0]    tr_local_idx;
    logic [GLOBAL_HISTORY_BITS-1:0] tr_global_idx;
    logic                           tr_local_right;
    logic                           tr_global_right;

    // saturating step toward up / down
    function automatic counter_t sat_step(counter_t ctr, logic up);
        counter_t next;
        next = ctr;
        if (up && ctr != 2'b11) begin
            next = ctr + 2'b01;
        end else if (!up && ctr != 2'b00) begin
            next = ctr - 2'b01;
        end
        return next;
    endfunction

    // lookup side, word-aligned pc bits
    assign lk_local_idx  = lookup_pc[LOCAL_INDEX_BITS+1:2];
    assign lk_global_idx = lookup_pc[GLOBAL_HISTORY_BITS+1:2] ^ history;

    assign lk_local_taken  = local_table[lk_local_idx][1];
    assign lk_global_taken = global_table[lk_global_idx][1];
    // meta msb set picks global
    assign lk_use_global   = meta_table[lk_local_idx][1];

    assign pred_taken = lk_use_global ? lk_global_taken : lk_local_taken;

    // training side, history as it stands at resolution
    assign tr_local_idx  = train_pc[LOCAL_INDEX_BITS+1:2];
    assign tr_global_idx = train_pc[GLOBAL_HISTORY_BITS+1:2] ^ history;

    // which components would have called it right
    assign tr_local_right  = (local_table[tr_local_idx][1] == train_taken);
    assign tr_global_right = (global_table[tr_global_idx][1] == train_taken);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                local_table[i]  <= COUNTER_RESET;
                global_table[i] <= COUNTER_RESET;
                meta_table[i]   <= COUNTER_RESET;
            end
            history <= '0;
        end else if (train_valid) begin
            local_table[tr_local_idx]   <= sat_step(local_table[tr_local_idx], train_taken);
            global_table[tr_global_idx] <= sat_step(global_table[tr_global_idx], train_taken);
            // meta only learns when the two disagree
            if (tr_local_right != tr_global_right) begin
                meta_table[tr_local_idx] <= sat_step(meta_table[tr_local_idx],
                                                     tr_global_right);
            end
            history <= {history[GLOBAL_HISTORY_BITS-2:0], train_taken};
        end
    end

    // an X outcome would poison tables and history
    a_train_known: assert property (@(posedge clk) disable iff (reset)
        train_valid |-> !$isunknown(train_taken));

endmodule

//--- verif/branch_unit_tb.sv
module branch_unit_tb;
    import rv_isa_pkg::*;
    import bpred_pkg::*;

    localparam int RESET_CYCLES = 16;
    // issue cycles per test, spacing included
    localparam int COND_CYCLES  = 36;
    localparam int JUMP_CYCLES  = 4;
    localparam int MIX_CYCLES   = 6;
    localparam int LOOP_CYCLES  = 8 * 4;
    localparam int ALT_CYCLES   = 12 * 4;
    localparam int RESET_TEST_CYCLES = 2 + 4 + 1 + 4;
    // pipeline drain after each of six tests, plus the final idle
    localparam int DRAIN_CYCLES = 6 * 4 + 4;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + COND_CYCLES + JUMP_CYCLES + MIX_CYCLES
                                + LOOP_CYCLES + ALT_CYCLES + RESET_TEST_CYCLES
                                + DRAIN_CYCLES + 100;

    logic         clk;
    logic         reset;
    logic         instr_valid;
    logic [31:0]  instr_pc;
    logic [31:0]  instr_word;
    logic [31:0]  rs1_data;
    logic [31:0]  rs2_data;
    logic         result_valid;
    branch_kind_e result_kind;
    logic         result_taken;
    logic [31:0]  result_pc_next;
    logic [31:0]  link_data;
    logic         mispredict;

    typedef struct packed {
        branch_kind_e kind;
        logic         taken;
        logic [31:0]  pc_next;
        logic [31:0]  link;
        logic         mp;
        logic         check_mp;
    } expect_t;

    expect_t     exp_q[$];
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count  = 0;
    logic [31:0] rng_state    = 32'hb9593855;

    // reference predictor tables
    counter_t    ref_local  [TABLE_ENTRIES];
    counter_t    ref_global [TABLE_ENTRIES];
    counter_t    ref_meta   [TABLE_ENTRIES];
    logic [5:0]  ref_history;

    branch_unit_top uut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_kind(string name, branch_kind_e got, branch_kind_e exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // saturating 2-bit step
    function automatic counter_t toward(counter_t c, logic up);
        if (up && c != 2'b11) begin
            return c + 2'b01;
        end else if (!up && c != 2'b00) begin
            return c - 2'b01;
        end
        return c;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            ref_local[i]  = COUNTER_RESET;
            ref_global[i] = COUNTER_RESET;
            ref_meta[i]   = COUNTER_RESET;
        end
        ref_history = '0;
    endtask

    // meta msb picks global, else local
    function automatic logic model_predict(logic [31:0] pc);
        logic [5:0] li;
        logic [5:0] gi;
        li = pc[7:2];
        gi = pc[7:2] ^ ref_history;
        return ref_meta[li][1] ? ref_global[gi][1] : ref_local[li][1];
    endfunction

    task automatic model_train(logic [31:0] pc, logic taken);
        logic [5:0] li;
        logic [5:0] gi;
        logic       local_right;
        logic       global_right;
        li = pc[7:2];
        gi = pc[7:2] ^ ref_history;
        local_right  = (ref_local[li][1] == taken);
        global_right = (ref_global[gi][1] == taken);
        ref_local[li]  = toward(ref_local[li], taken);
        ref_global[gi] = toward(ref_global[gi], taken);
        // meta only moves on disagreement
        if (local_right != global_right) begin
            ref_meta[li] = toward(ref_meta[li], global_right);
        end
        ref_history = {ref_history[4:0], taken};
    endtask

    function automatic logic cond_outcome(branch_funct3_e f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            BGEU:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // rs1 = x1, rs2 = x2, rd = x1
    function automatic logic [31:0] enc_branch(branch_funct3_e f3, logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_jalr(logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd1, OPC_JALR};
    endfunction

    // called at posedge + 1, returns at posedge + 1
    task automatic drive(logic [31:0] pc, logic [31:0] word, logic [31:0] a,
                         logic [31:0] b, int gap);
        instr_valid = 1'b1;
        instr_pc    = pc;
        instr_word  = word;
        rs1_data    = a;
        rs2_data    = b;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        repeat (gap - 1) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_cond(logic [31:0] pc, branch_funct3_e f3, logic [12:0] imm,
                             logic [31:0] a, logic [31:0] b, logic check_mp, int gap);
        expect_t     e;
        logic        pred;
        logic [31:0] imm32;
        imm32      = {{19{imm[12]}}, imm};
        pred       = model_predict(pc);
        e.kind     = KIND_COND;
        e.taken    = cond_outcome(f3, a, b);
        e.pc_next  = e.taken ? pc + imm32 : pc + 32'd4;
        e.link     = pc + 32'd4;
        e.mp       = (pred != e.taken);
        e.check_mp = check_mp;
        // in-order training leaves the tables as the DUT has them
        model_train(pc, e.taken);
        exp_q.push_back(e);
        drive(pc, enc_branch(f3, imm), a, b, gap);
    endtask

    task automatic send_jal(logic [31:0] pc, logic [20:0] imm, int gap);
        expect_t e;
        e.kind     = KIND_JAL;
        e.taken    = 1'b1;
        e.pc_next  = pc + {{11{imm[20]}}, imm};
        e.link     = pc + 32'd4;
        e.mp       = 1'b0;
        e.check_mp = 1'b1;
        exp_q.push_back(e);
        drive(pc, enc_jal(imm), next_random(), next_random(), gap);
    endtask

    task automatic send_jalr(logic [31:0] pc, logic [11:0] imm, logic [31:0] base, int gap);
        expect_t e;
        e.kind     = KIND_JALR;
        e.taken    = 1'b1;
        // halfword bit dropped from the sum
        e.pc_next  = (base + {{20{imm[11]}}, imm}) & 32'hffff_fffe;
        e.link     = pc + 32'd4;
        e.mp       = 1'b1;
        e.check_mp = 1'b1;
        exp_q.push_back(e);
        drive(pc, enc_jalr(imm), base, next_random(), gap);
    endtask

    task automatic drain_results();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    // results sampled mid-cycle, in issue order
    always @(negedge clk) begin : monitor
        expect_t e;
        if (!reset && result_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("result_valid seen with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                check_kind("result_kind", result_kind, e.kind);
                check_bit("result_taken", result_taken, e.taken);
                check_word("result_pc_next", result_pc_next, e.pc_next);
                check_word("link_data", link_data, e.link);
                if (e.check_mp) begin
                    check_bit("mispredict", mispredict, e.mp);
                end
            end
        end
    end

    // six compares over edge and random operands, back to back
    task automatic test_cond_compares();
        branch_funct3_e f3_list [6];
        logic [31:0]    a_vals [6];
        logic [31:0]    b_vals [6];
        logic [31:0]    r;
        r = next_random();
        f3_list = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        a_vals  = '{r, 32'h7fffffff, 32'h80000000, 32'h0, next_random(), next_random()};
        b_vals  = '{r, 32'h80000000, 32'h7fffffff, 32'hffffffff, next_random(), r};
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 6; p++) begin
                send_cond(32'h1000 + 32'(f * 24 + p * 4), f3_list[f],
                          (p % 2) ? 13'h1ff0 : 13'h0040, a_vals[p], b_vals[p], 1'b0, 1);
            end
        end
    endtask

    task automatic test_jumps();
        send_jal(32'h2000, 21'h000800, 1);
        send_jal(32'h2004, 21'h1ffff0, 1);
        // odd sum, bit 0 must clear
        send_jalr(32'h2008, 12'h005, 32'h0000_3000, 1);
        send_jalr(32'h200c, 12'hfff, next_random(), 1);
    endtask

    // addi, unused branch funct3 and a load are dropped at decode
    task automatic test_non_branch();
        send_cond(32'h3000, BEQ, 13'h0020, 32'd5, 32'd5, 1'b0, 1);
        drive(32'h3004, 32'h0050_0093, next_random(), next_random(), 1);
        send_jal(32'h3008, 21'h000100, 1);
        drive(32'h300c, 32'h0000_2063, next_random(), next_random(), 1);
        drive(32'h3010, 32'h0000_a083, next_random(), next_random(), 1);
        send_jalr(32'h3014, 12'h010, 32'h0000_4000, 1);
    endtask

    task automatic test_loop();
        for (int i = 0; i < 8; i++) begin
            send_cond(32'h4000, BNE, 13'h1ff8, 32'(i + 1), 32'd0, 1'b1, 4);
        end
    endtask

    // taken on odd issues only
    task automatic test_alternate();
        for (int i = 0; i < 12; i++) begin
            send_cond(32'h5000, BEQ, 13'h0010, 32'(i), (i % 2) ? 32'(i) : 32'(i + 1), 1'b1, 4);
        end
    endtask

    task automatic test_mid_reset();
        send_cond(32'h6000, BLT, 13'h0040, 32'd1, 32'd2, 1'b0, 1);
        send_cond(32'h6004, BGE, 13'h0040, 32'd1, 32'd2, 1'b0, 1);
        reset = 1'b1;
        // both branches would reach result during these edges
        repeat (4) begin
            @(posedge clk);
            #1;
            check_bit("result_valid", result_valid, 1'b0);
        end
        exp_q.delete();
        model_reset();
        reset = 1'b0;
        @(posedge clk);
        #1;
        // loop pc was trained taken, fresh tables say not-taken
        send_cond(32'h4000, BNE, 13'h1ff8, 32'd1, 32'd0, 1'b1, 4);
    endtask

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_pc    = '0;
        instr_word  = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        test_cond_compares();
        drain_results();
        test_jumps();
        drain_results();
        test_non_branch();
        drain_results();
        test_loop();
        drain_results();
        test_alternate();
        drain_results();
        test_mid_reset();
        drain_results();
        // idle tail catches stray results
        repeat (4) @(posedge clk);
        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
